// ==== mem_bank.sv ====
`timescale 1ns/1ps

module mem_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  mem_types_pkg::bank_req_t  req,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output mem_types_pkg::mem_rsp_t   rsp
);

    import mem_map_pkg::*;
    import mem_types_pkg::*;

    logic [data_w-1:0] mem [bank_words];

    logic [bank_addr_w-1:0] word_idx;
    logic accept;
    logic is_read;

    // the response register blocks new requests only while it is full and stalled
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept = req_valid && req_ready;
    assign is_read = req.req.op == op_read;
    assign word_idx = req.req.addr[bank_addr_w-1:0];  // already local to this bank

    always_ff @(posedge clk) begin
        if (accept && !is_read) begin
            for (int i = 0; i < mask_w; i++) begin
                if (req.req.wmask[i]) begin
                    mem[word_idx][i*8 +: 8] <= req.req.wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= is_read;  // an accepted write also ends a draining response
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_read) begin
            rsp.rdata <= mem[word_idx];
            rsp.tag <= req.req.tag;
            rsp.src <= req.src;
        end
    end

endmodule

// ==== mem_crossbar.sv ====
`timescale 1ns/1ps

module mem_crossbar (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [mem_map_pkg::n_req-1:0]        req_valid,
    output logic [mem_map_pkg::n_req-1:0]        req_ready,
    input  mem_types_pkg::mem_req_t              req [mem_map_pkg::n_req],
    output logic [mem_map_pkg::n_bank-1:0]       bank_req_valid,
    input  logic [mem_map_pkg::n_bank-1:0]       bank_req_ready,
    output mem_types_pkg::bank_req_t             bank_req [mem_map_pkg::n_bank]
);

    import mem_map_pkg::*;
    import mem_types_pkg::*;

    typedef logic [req_idx_w-1:0] req_idx_t;

    req_idx_t prio;
    req_idx_t next_prio;

    logic [n_bank-1:0] bank_free;
    logic [n_bank-1:0] grant_bank;
    bank_req_t bank_req_next [n_bank];

    // an output register can take a new request when it is empty or drains this cycle
    assign bank_free = ~bank_req_valid | bank_req_ready;

    function automatic req_idx_t wrap_req(input int idx);
        return req_idx_t'(idx % n_req);
    endfunction

    // Requesters are scanned from the current priority. Every address falls in exactly one
    // bank, so a requester can win at most one bank per cycle.
    always_comb begin
        int r;
        logic [addr_w-1:0] offset;

        grant_bank = '0;
        req_ready = '0;
        next_prio = prio;
        r = 0;
        offset = '0;

        for (int b = 0; b < n_bank; b++) begin
            bank_req_next[b] = '0;
        end

        for (int i = 0; i < n_req; i++) begin
            r = int'(wrap_req(int'(prio) + i));
            for (int b = 0; b < n_bank; b++) begin
                // an address below the base wraps to a large offset and misses
                offset = req[r].addr - bank_base[b];
                if (req_valid[r] && offset <= (bank_last[b] - bank_base[b]) &&
                        bank_free[b] && !grant_bank[b]) begin
                    grant_bank[b] = 1'b1;
                    req_ready[r] = 1'b1;
                    bank_req_next[b].req = req[r];
                    bank_req_next[b].req.addr = offset;  // bank sees its local word index
                    bank_req_next[b].src = req_idx_t'(r);
                    next_prio = wrap_req(r + 1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prio <= '0;
            bank_req_valid <= '0;
        end else begin
            if (|grant_bank) begin
                prio <= next_prio;  // moves to the requester after the last winner
            end
            for (int b = 0; b < n_bank; b++) begin
                if (bank_free[b]) begin
                    bank_req_valid[b] <= grant_bank[b];
                end
            end
        end
    end

    // payload only loads on a grant, so a held request stays put under back-pressure
    always_ff @(posedge clk) begin
        for (int b = 0; b < n_bank; b++) begin
            if (grant_bank[b]) begin
                bank_req[b] <= bank_req_next[b];
            end
        end
    end

endmodule

// ==== mem_map_pkg.sv ====
package mem_map_pkg;

    localparam int n_req = 3;
    localparam int n_bank = 4;

    localparam int req_idx_w = 2;  // wide enough to number every requester
    localparam int bank_idx_w = 2;

    localparam int addr_w = 10;  // word address seen by the requesters
    localparam int bank_words = 256;
    localparam int bank_addr_w = 8;  // word index inside one bank

    // inclusive word range of each bank, entry 0 is bank 0
    localparam logic [n_bank-1:0][addr_w-1:0] bank_base = {
        10'd768,
        10'd512,
        10'd256,
        10'd0
    };

    localparam logic [n_bank-1:0][addr_w-1:0] bank_last = {
        10'd1023,
        10'd767,
        10'd511,
        10'd255
    };

endpackage

// ==== mem_subsystem.f ====
mem_map_pkg.sv
mem_types_pkg.sv
mem_crossbar.sv
mem_bank.sv
resp_router.sv
mem_subsystem.sv
mem_subsystem_sva.sv
tb_mem_subsystem.sv

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mem_map_pkg::n_req-1:0]     req_valid,
    output logic [mem_map_pkg::n_req-1:0]     req_ready,
    input  mem_types_pkg::mem_req_t           req [mem_map_pkg::n_req],
    output logic [mem_map_pkg::n_req-1:0]     rsp_valid,
    input  logic [mem_map_pkg::n_req-1:0]     rsp_ready,
    output mem_types_pkg::mem_rsp_t           rsp [mem_map_pkg::n_req]
);

    import mem_map_pkg::*;
    import mem_types_pkg::*;

    logic [n_bank-1:0] bank_req_valid;
    logic [n_bank-1:0] bank_req_ready;
    bank_req_t bank_req [n_bank];

    logic [n_bank-1:0] bank_rsp_valid;
    logic [n_bank-1:0] bank_rsp_ready;
    mem_rsp_t bank_rsp [n_bank];

    mem_crossbar u_crossbar (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .bank_req_valid (bank_req_valid),
        .bank_req_ready (bank_req_ready),
        .bank_req       (bank_req)
    );

    for (genvar k = 0; k < n_bank; k++) begin : g_bank
        mem_bank u_bank (
            .clk       (clk),
            .rst       (rst),
            .req_valid (bank_req_valid[k]),
            .req_ready (bank_req_ready[k]),
            .req       (bank_req[k]),
            .rsp_valid (bank_rsp_valid[k]),
            .rsp_ready (bank_rsp_ready[k]),
            .rsp       (bank_rsp[k])
        );
    end

    // responses go back by source number, in no fixed order across banks
    resp_router u_router (
        .clk            (clk),
        .rst            (rst),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp_ready (bank_rsp_ready),
        .bank_rsp       (bank_rsp),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp)
    );

endmodule

// ==== mem_subsystem_sva.sv ====
`timescale 1ns/1ps

module mem_subsystem_sva (
    input logic                            clk,
    input logic                            rst,
    input logic [mem_map_pkg::n_req-1:0]   req_valid,
    input logic [mem_map_pkg::n_req-1:0]   req_ready,
    input logic [mem_map_pkg::n_bank-1:0]  bank_req_valid,
    input logic [mem_map_pkg::n_bank-1:0]  bank_req_ready,
    input mem_types_pkg::bank_req_t        bank_req [mem_map_pkg::n_bank]
);

    import mem_map_pkg::*;

    for (genvar b = 0; b < n_bank; b++) begin : g_bank
        // a stalled request keeps valid and payload until the bank takes it
        held_req_stable : assert property (@(posedge clk) disable iff (rst)
            bank_req_valid[b] && !bank_req_ready[b]
            |=> bank_req_valid[b] && $stable(bank_req[b]))
            else $error("bank %0d request changed while stalled", b);
    end

    no_valid_in_reset : assert property (@(posedge clk)
        rst && $past(rst) |-> bank_req_valid == '0)
        else $error("bank request valid while reset is held");

    for (genvar r = 0; r < n_req; r++) begin : g_req
        ready_needs_valid : assert property (@(posedge clk) disable iff (rst)
            req_ready[r] |-> req_valid[r])
            else $error("requester %0d ready without valid", r);
    end

endmodule

bind mem_crossbar mem_subsystem_sva u_sva (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .bank_req_valid (bank_req_valid),
    .bank_req_ready (bank_req_ready),
    .bank_req       (bank_req)
);

// ==== mem_types_pkg.sv ====
package mem_types_pkg;

    localparam int data_w = 32;
    localparam int mask_w = 4;  // one enable bit per byte of data
    localparam int tag_w = 4;

    typedef enum logic {
        op_read = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // request as driven by a requester
    typedef struct packed {
        mem_op_e op;
        logic [mem_map_pkg::addr_w-1:0] addr;
        logic [mask_w-1:0] wmask;
        logic [data_w-1:0] wdata;
        logic [tag_w-1:0] tag;  // chosen by the requester, echoed in the response
    } mem_req_t;

    // request as delivered to a bank
    typedef struct packed {
        mem_req_t req;
        logic [mem_map_pkg::req_idx_w-1:0] src;  // number of the requester that won
    } bank_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic [tag_w-1:0] tag;
        logic [mem_map_pkg::req_idx_w-1:0] src;
    } mem_rsp_t;

endpackage

// ==== resp_router.sv ====
`timescale 1ns/1ps

module resp_router (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mem_map_pkg::n_bank-1:0]    bank_rsp_valid,
    output logic [mem_map_pkg::n_bank-1:0]    bank_rsp_ready,
    input  mem_types_pkg::mem_rsp_t           bank_rsp [mem_map_pkg::n_bank],
    output logic [mem_map_pkg::n_req-1:0]     rsp_valid,
    input  logic [mem_map_pkg::n_req-1:0]     rsp_ready,
    output mem_types_pkg::mem_rsp_t           rsp [mem_map_pkg::n_req]
);

    import mem_map_pkg::*;
    import mem_types_pkg::*;

    typedef logic [bank_idx_w-1:0] bank_idx_t;
    typedef logic [req_idx_w-1:0] req_idx_t;

    bank_idx_t ptr [n_req];  // bank that gets first look for each requester
    bank_idx_t sel [n_req];

    function automatic bank_idx_t wrap_bank(input int idx);
        return bank_idx_t'(idx % n_bank);
    endfunction

    // Each bank response names one requester, so no bank is chosen twice and the
    // ready of a bank comes from at most one requester.
    always_comb begin
        int b;

        bank_rsp_ready = '0;
        rsp_valid = '0;
        b = 0;

        for (int r = 0; r < n_req; r++) begin
            rsp[r] = '0;
            sel[r] = ptr[r];
            for (int i = 0; i < n_bank; i++) begin
                b = int'(wrap_bank(int'(ptr[r]) + i));
                if (!rsp_valid[r] && bank_rsp_valid[b] &&
                        bank_rsp[b].src == req_idx_t'(r)) begin
                    rsp_valid[r] = 1'b1;
                    rsp[r] = bank_rsp[b];
                    sel[r] = bank_idx_t'(b);
                    bank_rsp_ready[b] = rsp_ready[r];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < n_req; r++) begin
                ptr[r] <= '0;
            end
        end else begin
            for (int r = 0; r < n_req; r++) begin
                if (rsp_valid[r] && rsp_ready[r]) begin
                    ptr[r] <= wrap_bank(int'(sel[r]) + 1);  // skip past the bank just served
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f mem_subsystem.f --top-module tb_mem_subsystem -o tb_mem_subsystem
./obj_dir/tb_mem_subsystem 2>&1 | tee sim.log

if grep -q "^sim passed$" sim.log; then
    echo "result: simulation reported success"
    exit 0
fi
echo "result: simulation reported failure"
exit 1

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

    import mem_map_pkg::*;
    import mem_types_pkg::*;

    typedef logic [addr_w-1:0] addr_t;

    localparam int n_tags = 1 << tag_w;
    localparam int slots = 8;  // words of each requester's slice in every bank

    logic clk;
    logic rst;
    logic [n_req-1:0] req_valid;
    logic [n_req-1:0] req_ready;
    mem_req_t req [n_req];
    logic [n_req-1:0] rsp_valid;
    logic [n_req-1:0] rsp_ready;
    mem_rsp_t rsp [n_req];

    logic [data_w-1:0] ref_mem [1 << addr_w];
    logic [n_tags-1:0] pending_valid [n_req];
    logic [data_w-1:0] pending_data [n_req][n_tags];
    logic [tag_w-1:0] next_tag [n_req];
    logic [31:0] rng_state [n_req+1];  // one stream per requester plus one for rsp_ready
    logic bp_on;
    logic fair_on;
    int others_won [n_req];

    mem_subsystem u_dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw(input int stream);
        rng_state[stream] = lcg(rng_state[stream]);
        return rng_state[stream];
    endfunction

    // expected word after a byte-masked write
    function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
            input logic [data_w-1:0] new_word, input logic [mask_w-1:0] mask);
        logic [data_w-1:0] result;
        result = old_word;
        for (int i = 0; i < mask_w; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic addr_t slot_addr(input int r, input int b, input int s);
        return addr_t'(b * bank_words + r * slots + s);
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int r = 0; r < n_req; r++) begin
            n += $countones(pending_valid[r]);
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic issue(input int r, input logic wr, input addr_t addr,
                         input logic [mask_w-1:0] mask);
        mem_req_t q;
        logic [tag_w-1:0] tag;
        logic accepted;
        int cycles;
        tag = next_tag[r];
        cycles = 0;
        while (!wr && pending_valid[r][tag]) begin  // a read tag is reused only once answered
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles < 1000) else report_failure(
                $sformatf("timeout: requester %0d found no free tag", r));
        end
        q = '0;
        q.op = wr ? op_write : op_read;
        q.addr = addr;
        q.tag = tag;
        if (wr) begin
            q.wmask = mask;
            q.wdata = draw(r);
        end
        req[r] = q;
        req_valid[r] = 1'b1;
        accepted = 1'b0;
        cycles = 0;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready[r];
            cycles++;
            assert (accepted || cycles < 200) else report_failure(
                $sformatf("timeout: request of requester %0d was never accepted", r));
        end
        if (wr) begin
            ref_mem[addr] = merge_bytes(ref_mem[addr], q.wdata, mask);
        end else begin
            pending_data[r][tag] = ref_mem[addr];
            pending_valid[r][tag] = 1'b1;
        end
        next_tag[r] = tag + 1'b1;
        #1;
        req_valid[r] = 1'b0;
    endtask

    task automatic drive_phase(input int r, input int phase);
        logic [31:0] v;
        addr_t addr;
        int n_ops;
        case (phase)
            0: n_ops = 2 * n_bank * slots;
            4: n_ops = 150;
            default: n_ops = n_bank * slots;
        endcase
        addr = '0;
        for (int i = 0; i < n_ops; i++) begin
            v = draw(r);
            case (phase)
                0: issue(r, i < n_bank * slots,
                         slot_addr(r, (i / slots) % n_bank, i % slots), '1);
                1: begin
                    if (i % 2 == 0) begin
                        addr = slot_addr(r, int'(v[19:18]), int'(v[22:20]));
                    end
                    issue(r, i % 2 == 0, addr, v[27:24]);  // odd steps read the merge back
                end
                2: issue(r, v[16], slot_addr(r, 0, int'(v[22:20])), v[27:24]);
                3: issue(r, 1'b0, slot_addr(r, i / slots, i % slots), '0);
                default: issue(r, v[16], slot_addr(r, int'(v[19:18]), int'(v[22:20])),
                               v[27:24]);
            endcase
        end
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (count_pending() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            assert (cycles < 2000) else report_failure(
                $sformatf("timeout: %0d reads still unanswered", count_pending()));
        end
    endtask

    task automatic run_phase(input int phase);
        fork
            drive_phase(0, phase);
            drive_phase(1, phase);
            drive_phase(2, phase);
        join
        wait_drained();
    endtask

    always @(posedge clk) begin
        mem_rsp_t got;
        if (!rst) begin
            for (int r = 0; r < n_req; r++) begin
                if (rsp_valid[r] && rsp_ready[r]) begin
                    got = rsp[r];
                    assert (int'(got.src) == r) else report_failure($sformatf(
                        "Error at %0t: requester %0d got src %0d", $time, r, got.src));
                    assert (pending_valid[r][got.tag]) else report_failure($sformatf(
                        "Error at %0t: requester %0d got unexpected tag %0d",
                        $time, r, got.tag));
                    assert (got.rdata == pending_data[r][got.tag]) else report_failure(
                        $sformatf("Error at %0t: requester %0d tag %0d read %h, expected %h",
                        $time, r, got.tag, got.rdata, pending_data[r][got.tag]));
                    pending_valid[r][got.tag] = 1'b0;
                end
            end
        end
    end

    // while all requesters share bank 0, a waiter sees at most two other grants
    always @(posedge clk) begin
        for (int s = 0; s < n_req; s++) begin
            if (!fair_on || !req_valid[s] || req_ready[s]) begin
                others_won[s] = 0;
            end else if (|(req_valid & req_ready)) begin
                others_won[s]++;
                assert (others_won[s] <= 2) else report_failure($sformatf(
                    "Error at %0t: requester %0d passed over %0d times",
                    $time, s, others_won[s]));
            end
        end
    end

    initial begin
        logic [31:0] bits;
        forever begin
            @(posedge clk);
            #1;
            bits = draw(n_req);
            rsp_ready = bp_on ? bits[18:16] : '1;
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = '0;
        rsp_ready = '1;
        bp_on = 1'b0;
        fair_on = 1'b0;
        for (int r = 0; r < n_req; r++) begin
            req[r] = '0;
            pending_valid[r] = '0;
            next_tag[r] = '0;
        end
        for (int i = 0; i <= n_req; i++) begin
            rng_state[i] = lcg(32'h5b25 + i);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(posedge clk);
            assert (rsp_valid == '0 && req_ready == '0) else report_failure($sformatf(
                "Error at %0t: req_ready or rsp_valid high with no request", $time));
        end
        #1;
        run_phase(0);  // full words into every slice, then read back
        run_phase(1);
        fair_on = 1'b1;
        run_phase(2);
        fair_on = 1'b0;
        bp_on = 1'b1;
        run_phase(3);
        run_phase(4);
        // with every read answered, a response still offered is a duplicate
        if (count_pending() == 0 && rsp_valid == '0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Error at %0t: %0d reads pending, rsp_valid %b after draining",
                     $time, count_pending(), rsp_valid);
            $display("sim failed");
            $fatal(1, "pending reads or stray responses at the end");
        end
    end

endmodule
